/* rtl/scroll_cfg_pkg.sv */
/*
 * scroll line engine configuration
 * line geometry, memory port widths, tile size codes and register map
 */
`default_nettype none

package scroll_cfg_pkg;

    localparam int line_pixels = 448;   // visible pixels, buffer 0 to 447
    localparam int buf_aw      = 9;
    localparam int map_aw      = 13;    // row, column, word select
    localparam int rom_aw      = 20;    // ROM word address
    localparam int axi_aw      = 5;

    // one-hot tile size held in ctrl[2:0]
    localparam logic [2:0] size_8  = 3'b001;
    localparam logic [2:0] size_16 = 3'b010;
    localparam logic [2:0] size_32 = 3'b100;

    // register byte offsets
    localparam logic [axi_aw-1:0] reg_ctrl   = 5'h00;   // size, flip
    localparam logic [axi_aw-1:0] reg_hpos   = 5'h04;
    localparam logic [axi_aw-1:0] reg_vpos   = 5'h08;
    localparam logic [axi_aw-1:0] reg_bank   = 5'h0c;   // offset, mask, limit
    localparam logic [axi_aw-1:0] reg_status = 5'h10;

endpackage

`default_nettype wire

/* rtl/scroll_gfx_pkg.sv */
/*
 * scroll graphics formats
 * tile attribute fields, pixel word layout and planar ROM words
 */
`default_nettype none

package scroll_gfx_pkg;

    // attribute word of a tile map entry
    localparam int attr_pal_lsb   = 0;
    localparam int attr_pal_w     = 5;
    localparam int attr_hflip_bit = 5;
    localparam int attr_vflip_bit = 6;
    localparam int attr_group_lsb = 7;    // two bits of priority group

    localparam int colour_w = 4;
    localparam int pixel_w  = 11;         // group, palette, colour

    // a ROM word holds 8 pixels as four planes of one byte each
    localparam int rom_dw          = 32;
    localparam int pixels_per_word = 8;

    localparam logic [colour_w-1:0] unmapped_colour = 4'hf;

    // colour of the leftmost pixel, or the rightmost one when flipped
    function automatic logic [colour_w-1:0] plane_colour(
        input logic [rom_dw-1:0] w,
        input logic              hflip
    );
        return hflip ? {w[24], w[16], w[8], w[0]} : {w[31], w[23], w[15], w[7]};
    endfunction

endpackage

`default_nettype wire

/* rtl/scroll_regs.sv */
/*
 * scroll register block
 * AXI4-Lite slave for control, scroll position and bank mapping,
 * plus a sticky line done flag
 */
`timescale 1ns/10ps
`default_nettype none

module scroll_regs
    import scroll_cfg_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire [axi_aw-1:0]  awaddr,
    input  wire               awvalid,
    output logic              awready,
    input  wire [31:0]        wdata,
    input  wire [3:0]         wstrb,
    input  wire               wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  wire               bready,
    input  wire [axi_aw-1:0]  araddr,
    input  wire               arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  wire               rready,
    input  wire               line_done,
    input  wire               line_start,
    output logic [2:0]        size,
    output logic              flip,
    output logic [15:0]       hpos,
    output logic [15:0]       vpos,
    output logic [3:0]        bank_offset,
    output logic [3:0]        bank_mask,
    output logic [3:0]        bank_limit
);

logic [15:0] ctrl_r;
logic [15:0] bank_r;
logic        done_r;
logic        wr_go;
logic        rd_go;
logic [31:0] rd_word;

function automatic logic [15:0] merge(
    input logic [15:0] old,
    input logic [15:0] data,
    input logic [1:0]  strb
);
    return {strb[1] ? data[15:8] : old[15:8], strb[0] ? data[7:0] : old[7:0]};
endfunction

// write needs address and data together, one response outstanding
assign wr_go   = awvalid && wvalid && !bvalid;
assign awready = wr_go;
assign wready  = wr_go;
assign rd_go   = arvalid && !rvalid;
assign arready = rd_go;
assign bresp   = 2'b00;     // always OKAY
assign rresp   = 2'b00;

assign size        = ctrl_r[2:0];
assign flip        = ctrl_r[8];
assign bank_offset = bank_r[3:0];
assign bank_mask   = bank_r[7:4];
assign bank_limit  = bank_r[11:8];

always_comb begin
    case (araddr)
        reg_ctrl:   rd_word = {16'h0, ctrl_r};
        reg_hpos:   rd_word = {16'h0, hpos};
        reg_vpos:   rd_word = {16'h0, vpos};
        reg_bank:   rd_word = {16'h0, bank_r};
        reg_status: rd_word = {31'h0, done_r};
        default:    rd_word = 32'h0;
    endcase
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        ctrl_r <= {13'h0, size_8};
        hpos   <= 16'h0;
        vpos   <= 16'h0;
        bank_r <= 16'h0;
        done_r <= 1'b0;
        bvalid <= 1'b0;
        rvalid <= 1'b0;
        rdata  <= 32'h0;
    end else begin
        if (wr_go) begin
            bvalid <= 1'b1;
            case (awaddr)
                reg_ctrl: ctrl_r <= merge(ctrl_r, wdata[15:0], wstrb[1:0]);
                reg_hpos: hpos   <= merge(hpos, wdata[15:0], wstrb[1:0]);
                reg_vpos: vpos   <= merge(vpos, wdata[15:0], wstrb[1:0]);
                reg_bank: bank_r <= merge(bank_r, wdata[15:0], wstrb[1:0]);
                default: ;        // status and holes are read only
            endcase
        end else if (bready) begin
            bvalid <= 1'b0;
        end
        if (rd_go) begin
            rvalid <= 1'b1;
            rdata  <= rd_word;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
        if (line_start) begin
            done_r <= 1'b0;
        end else if (line_done) begin
            done_r <= 1'b1;
        end
    end
end

endmodule

`default_nettype wire

/* rtl/tile_fetch.sv */
/*
 * tile fetch stage
 * reads the code and attribute words of each tile map entry and
 * hands the pixel stage a mapped ROM base, one tile ahead
 */
`timescale 1ns/10ps
`default_nettype none

module tile_fetch
    import scroll_cfg_pkg::*;
    import scroll_gfx_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start,
    input  wire                   stop,
    input  wire [2:0]             size,
    input  wire                   flip,
    input  wire [8:0]             vrender,
    input  wire [15:0]            hpos,
    input  wire [15:0]            vpos,
    input  wire [3:0]             bank_offset,
    input  wire [3:0]             bank_mask,
    input  wire [3:0]             bank_limit,
    output logic [map_aw-1:0]     map_addr,
    input  wire [15:0]            map_data,
    output logic                  tile_valid,
    output logic [rom_aw-1:0]     rom_base,
    output logic                  first_half,
    output logic                  tile_hflip,
    output logic [attr_pal_w-1:0] tile_pal,
    output logic [1:0]            tile_group,
    output logic                  tile_unmapped,
    output logic [4:0]            skip,
    input  wire                   tile_ready,
    input  wire                   line_end
);

typedef enum logic [2:0] {st_idle, st_code, st_attr, st_dec, st_hold} state_t;

state_t            st;
logic [5:0]        row_r;
logic [5:0]        col_r;
logic [4:0]        fine_r;      // pixel row inside the tile
logic [15:0]       code_r;
logic [8:0]        attr_r;
logic [8:0]        attr_w;
logic [8:0]        line_n;
logic [15:0]       vn;
logic [5:0]        row_c;
logic [5:0]        col_c;
logic [4:0]        skip_c;
logic [4:0]        prow;
logic [rom_aw-1:0] pre_addr;
logic [3:0]        top;
logic              push;

// first tile row, column and fine scroll of the line
always_comb begin
    line_n = flip ? {vrender[8], ~vrender[7:0]} : vrender;
    vn     = vpos + {7'd0, line_n};
    case (size)
        size_16: begin
            row_c  = vn[9:4];
            col_c  = hpos[9:4];
            skip_c = {1'b0, hpos[3:0]};
        end
        size_32: begin
            row_c  = vn[10:5];
            col_c  = hpos[10:5];
            skip_c = hpos[4:0];
        end
        default: begin  // 8x8, also any size that is not one-hot
            row_c  = vn[8:3];
            col_c  = hpos[8:3];
            skip_c = {2'b0, hpos[2:0]};
        end
    endcase
end

// attributes come straight from the map, or from attr_r while held
assign attr_w = (st == st_dec) ? map_data[8:0] : attr_r;
assign push   = (st == st_dec || st == st_hold) && (!tile_valid || tile_ready);

always_comb begin
    prow = fine_r ^ {5{attr_w[attr_vflip_bit]}};
    case (size)
        size_16: pre_addr = {code_r, prow[3:0]};
        size_32: pre_addr = {code_r[13:0], prow, 1'b0};  // word bit from pixel stage
        default: pre_addr = {1'b0, code_r, prow[2:0]};
    endcase
    top = pre_addr[rom_aw-1 -: 4];
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        st         <= st_idle;
        tile_valid <= 1'b0;
        map_addr   <= '0;
    end else begin
        if (tile_valid && tile_ready) begin
            tile_valid <= 1'b0;
        end
        case (st)
            st_idle: begin
                if (start) begin
                    map_addr <= {row_c, col_c, 1'b0};
                    st       <= st_code;
                end
            end
            st_code: begin
                map_addr[0] <= 1'b1;   // attribute word next
                st          <= st_attr;
            end
            st_attr: st <= st_dec;
            default: begin
                if (push) begin
                    tile_valid <= 1'b1;
                    map_addr   <= {row_r, col_r + 6'd1, 1'b0};
                    st         <= st_code;
                end else begin
                    st <= st_hold;     // pixel stage still busy
                end
            end
        endcase
        if (stop || line_end) begin
            st         <= st_idle;
            tile_valid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (st == st_idle && start) begin
        row_r  <= row_c;
        col_r  <= col_c;
        fine_r <= vn[4:0];
        skip   <= skip_c;
    end
    if (st == st_attr) begin
        code_r <= map_data;
    end
    if (st == st_dec) begin
        attr_r <= map_data[8:0];
    end
    if (push) begin
        col_r         <= col_r + 6'd1;     // wraps at 64
        rom_base      <= {(top & bank_mask) | bank_offset, pre_addr[rom_aw-5:0]};
        tile_unmapped <= top > bank_limit;
        first_half    <= attr_w[attr_hflip_bit];
        tile_hflip    <= attr_w[attr_hflip_bit];
        tile_pal      <= attr_w[attr_pal_lsb +: attr_pal_w];
        tile_group    <= attr_w[attr_group_lsb +: 2];
    end
end

endmodule

`default_nettype wire

/* rtl/pixel_fetch.sv */
/*
 * pixel fetch stage
 * requests the ROM words of each tile in flip order, unpacks the
 * planar pixels and writes them to the line buffer
 */
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch
    import scroll_cfg_pkg::*;
    import scroll_gfx_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   stop,
    input  wire [2:0]             size,
    input  wire                   tile_valid,
    input  wire [rom_aw-1:0]      rom_base,
    input  wire                   first_half,
    input  wire                   tile_hflip,
    input  wire [attr_pal_w-1:0]  tile_pal,
    input  wire [1:0]             tile_group,
    input  wire                   tile_unmapped,
    input  wire [4:0]             skip,
    output logic                  tile_ready,
    output logic                  rom_cs,
    output logic [rom_aw-1:0]     rom_addr,
    output logic                  rom_half,
    input  wire [rom_dw-1:0]      rom_data,
    input  wire                   rom_ok,
    output logic                  buf_wr,
    output logic [buf_aw-1:0]     buf_addr,
    output logic [pixel_w-1:0]    buf_data,
    output logic                  line_end,
    output logic                  done
);

logic                        run;         // first tile of the line taken
logic                        cur_valid;   // tile still has words to request
logic [1:0]                  step;
logic [rom_aw-1:0]           cur_base;
logic                        cur_half;
logic                        cur_hflip;
logic                        cur_unmapped;
logic [pixel_w-colour_w-1:0] cur_pre;     // group and palette
logic                        hold_full;
logic [rom_dw-1:0]           hold_data;
logic                        hold_hflip;
logic                        hold_unmapped;
logic [pixel_w-colour_w-1:0] hold_pre;
logic [rom_dw-1:0]           shift_r;
logic                        sh_hflip;
logic                        sh_unmapped;
logic [pixel_w-colour_w-1:0] sh_pre;
logic [3:0]                  sh_cnt;      // pixels left in shift_r
logic [buf_aw-1:0]           pos;
logic                        is16;
logic                        is32;
logic                        last_step;
logic                        accept;
logic                        issue;
logic                        take;
logic                        drain;
logic                        load;
logic [colour_w-1:0]         colour;

assign is16      = size == size_16;
assign is32      = size == size_32;
assign last_step = is32 ? (step == 2'd3) : (!is16 || step[0]);

assign tile_ready = tile_valid && !cur_valid;
assign accept     = tile_valid && tile_ready;
assign issue      = cur_valid && !rom_cs && !hold_full;
assign take       = rom_cs && rom_ok;
assign drain      = sh_cnt != 4'd0;
assign load       = hold_full && sh_cnt <= 4'd1;   // refill on the last pixel
assign line_end   = stop || (buf_wr && buf_addr == buf_aw'(line_pixels - 1));

assign colour = sh_unmapped ? unmapped_colour : plane_colour(shift_r, sh_hflip);

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        run       <= 1'b0;
        cur_valid <= 1'b0;
        step      <= 2'd0;
        rom_cs    <= 1'b0;
        hold_full <= 1'b0;
        sh_cnt    <= 4'd0;
        buf_wr    <= 1'b0;
        done      <= 1'b0;
    end else begin
        done   <= line_end;
        buf_wr <= drain;
        if (accept) begin
            cur_valid <= 1'b1;
            step      <= 2'd0;
            run       <= 1'b1;
        end
        if (issue) begin
            rom_cs <= 1'b1;   // held until rom_ok
        end
        if (take) begin
            rom_cs    <= 1'b0;
            hold_full <= 1'b1;
            step      <= step + 2'd1;
            cur_valid <= !last_step;
        end
        if (drain) begin
            sh_cnt <= sh_cnt - 4'd1;
        end
        if (load) begin
            hold_full <= 1'b0;
            sh_cnt    <= 4'(pixels_per_word);
        end
        if (line_end) begin
            run       <= 1'b0;
            cur_valid <= 1'b0;
            rom_cs    <= 1'b0;
            hold_full <= 1'b0;
            sh_cnt    <= 4'd0;
            buf_wr    <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        cur_base     <= rom_base;
        cur_half     <= first_half;
        cur_hflip    <= tile_hflip;
        cur_unmapped <= tile_unmapped;
        cur_pre      <= {tile_group, tile_pal};
        if (!run) begin
            pos <= buf_aw'(0) - buf_aw'(skip);   // fine scroll, wraps below 0
        end
    end
    if (issue) begin
        // 32x32 visits (half, word) 00 10 01 11, reversed when flipped
        rom_addr <= {cur_base[rom_aw-1:1], is32 ? step[1] ^ cur_hflip : cur_base[0]};
        rom_half <= cur_half ^ ((is16 || is32) && step[0]);
    end
    if (take) begin
        hold_data     <= rom_data;
        hold_hflip    <= cur_hflip;
        hold_unmapped <= cur_unmapped;
        hold_pre      <= cur_pre;
    end
    if (drain) begin
        buf_addr <= pos;
        buf_data <= {sh_pre, colour};
        pos      <= pos + 1'b1;
        shift_r  <= sh_hflip ? shift_r >> 1 : shift_r << 1;
    end
    if (load) begin
        shift_r     <= hold_data;
        sh_hflip    <= hold_hflip;
        sh_unmapped <= hold_unmapped;
        sh_pre      <= hold_pre;
    end
end

endmodule

`default_nettype wire

/* rtl/scroll_line_top.sv */
/*
 * scroll line engine top
 * register block feeding the tile and pixel fetch stages
 */
`timescale 1ns/10ps
`default_nettype none

module scroll_line_top
    import scroll_cfg_pkg::*;
    import scroll_gfx_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire [axi_aw-1:0]   awaddr,
    input  wire                awvalid,
    output wire                awready,
    input  wire [31:0]         wdata,
    input  wire [3:0]          wstrb,
    input  wire                wvalid,
    output wire                wready,
    output wire [1:0]          bresp,
    output wire                bvalid,
    input  wire                bready,
    input  wire [axi_aw-1:0]   araddr,
    input  wire                arvalid,
    output wire                arready,
    output wire [31:0]         rdata,
    output wire [1:0]          rresp,
    output wire                rvalid,
    input  wire                rready,
    input  wire                start,
    input  wire                stop,
    input  wire [8:0]          vrender,
    output wire [map_aw-1:0]   map_addr,
    input  wire [15:0]         map_data,
    output wire                rom_cs,
    output wire [rom_aw-1:0]   rom_addr,
    output wire                rom_half,
    input  wire [rom_dw-1:0]   rom_data,
    input  wire                rom_ok,
    output wire                buf_wr,
    output wire [buf_aw-1:0]   buf_addr,
    output wire [pixel_w-1:0]  buf_data,
    output wire                done
);

// register fields
wire [2:0]             size;
wire                   flip;
wire [15:0]            hpos;
wire [15:0]            vpos;
wire [3:0]             bank_offset;
wire [3:0]             bank_mask;
wire [3:0]             bank_limit;

// tile descriptor between the stages
wire                   tile_valid;
wire                   tile_ready;
wire [rom_aw-1:0]      rom_base;
wire                   first_half;
wire                   tile_hflip;
wire [attr_pal_w-1:0]  tile_pal;
wire [1:0]             tile_group;
wire                   tile_unmapped;
wire [4:0]             skip;
wire                   line_end;

scroll_regs scroll_regs_inst (
    .line_done  (done),
    .line_start (start),
    .*
);

tile_fetch tile_fetch_inst (
    .*
);

pixel_fetch pixel_fetch_inst (
    .*
);

endmodule

`default_nettype wire

/* test/tb_clock.sv */
/*
 * testbench clock
 * free running 20 ns clock
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk
);

initial clk = 1'b0;
always #10 clk = ~clk;   // 50 MHz

endmodule

`default_nettype wire

/* test/scroll_line_tb.sv */
/*
 * scroll line engine testbench
 * tile map, ROM and line buffer models, AXI4-Lite access and
 * directed tests checked against a pixel model of the render rules
 */
`timescale 1ns/10ps
`default_nettype none

module scroll_line_tb
    import scroll_cfg_pkg::*;
    import scroll_gfx_pkg::*;
;

localparam int     max_lat     = 6;
localparam int     done_limit  = line_pixels * max_lat * 2;   // cycles per line
localparam longint watchdog_ns = 64'd8 * line_pixels * max_lat * 20;

wire                 clk;
logic                rst;
logic [axi_aw-1:0]   awaddr;
logic                awvalid;
wire                 awready;
logic [31:0]         wdata;
logic [3:0]          wstrb;
logic                wvalid;
wire                 wready;
wire  [1:0]          bresp;
wire                 bvalid;
logic                bready;
logic [axi_aw-1:0]   araddr;
logic                arvalid;
wire                 arready;
wire  [31:0]         rdata;
wire  [1:0]          rresp;
wire                 rvalid;
logic                rready;
logic                start;
logic                stop;
logic [8:0]          vrender;
wire  [map_aw-1:0]   map_addr;
logic [15:0]         map_data = '0;
wire                 rom_cs;
wire  [rom_aw-1:0]   rom_addr;
wire                 rom_half;
logic [rom_dw-1:0]   rom_data = '0;
logic                rom_ok = 1'b0;
wire                 buf_wr;
wire  [buf_aw-1:0]   buf_addr;
wire  [pixel_w-1:0]  buf_data;
wire                 done;

logic [15:0]         map_mem [1 << map_aw];
logic [pixel_w-1:0]  line_mem [1 << buf_aw];
int                  wr_line [1 << buf_aw];   // line id of the last write
integer              seed;
int                  req_lat = 2;
int                  wait_cnt;
logic                rand_lat = 1'b0;
int                  line_id;
int                  done_line;
int                  wr_total;
int                  done_total;
int                  late_total;
int                  wr_base;
int                  done_base;
int                  late_base;
int                  errors;
int                  checks;
int                  tests;
logic [1:0]          last_bresp;   // response of the last write
logic [1:0]          last_rresp;   // response of the last read

// settings of the line being rendered
logic [2:0]          cfg_size;
logic                cfg_flip;
logic [15:0]         cfg_hpos;
logic [15:0]         cfg_vpos;
logic [3:0]          cfg_offset;
logic [3:0]          cfg_mask;
logic [3:0]          cfg_limit;

tb_clock clock_inst (.clk(clk));

scroll_line_top scroll_line_top_inst (.*);

// tile map, data one cycle after the address
always @(posedge clk) map_data <= map_mem[map_addr];

// ROM with a request held until rom_ok
always @(posedge clk) begin
    rom_ok <= 1'b0;
    if (!rom_cs || rom_ok) begin
        wait_cnt <= 0;
    end else if (wait_cnt + 1 >= req_lat) begin
        rom_ok   <= 1'b1;
        rom_data <= rom_word(rom_addr, rom_half);
        wait_cnt <= 0;
        req_lat  <= rand_lat ? 1 + int'($unsigned($random(seed)) % 6) : 2;
    end else begin
        wait_cnt <= wait_cnt + 1;
    end
end

// line buffer capture, writes with or after done counted as late
always @(posedge clk) begin
    if (buf_wr) begin
        line_mem[buf_addr] <= buf_data;
        wr_line[buf_addr]  <= line_id;
        wr_total           <= wr_total + 1;
        if (done || done_line == line_id) late_total <= late_total + 1;
    end
    if (done) begin
        done_total <= done_total + 1;
        done_line  <= line_id;
    end
end

function automatic logic [rom_dw-1:0] rom_word(input logic [rom_aw-1:0] addr, input logic half);
    logic [31:0] h;
    h = {11'd0, addr, half} * 32'h9e37_79b1;
    h = h ^ (h >> 13) ^ 32'h5bd1_e995;
    return h;
endfunction

// pixel at buffer address a from the render rules
function automatic logic [pixel_w-1:0] expected_pixel(input int a);
    int                  w;
    int                  off;
    int                  px;
    int                  col;
    int                  row;
    int                  k;
    int                  i;
    logic [8:0]          line_n;
    logic [15:0]         vn;
    logic [15:0]         code;
    logic [15:0]         attr;
    logic [4:0]          prow;
    logic [rom_aw-1:0]   pre;
    logic [rom_aw-1:0]   addr;
    logic [3:0]          top;
    logic                hf;
    logic                half;
    logic                wbit;
    logic [rom_dw-1:0]   word;
    logic [colour_w-1:0] colour;
    w      = (cfg_size == size_16) ? 16 : (cfg_size == size_32) ? 32 : 8;
    off    = a + int'(cfg_hpos) % w;                // fine scroll shifts the tiles left
    px     = off % w;
    col    = (int'(cfg_hpos) / w + off / w) % 64;
    line_n = cfg_flip ? {vrender[8], ~vrender[7:0]} : vrender;
    vn     = cfg_vpos + {7'd0, line_n};
    row    = (int'(vn) / w) % 64;
    code   = map_mem[{row[5:0], col[5:0], 1'b0}];
    attr   = map_mem[{row[5:0], col[5:0], 1'b1}];
    hf     = attr[attr_hflip_bit];
    prow   = 5'(int'(vn) % w);
    if (attr[attr_vflip_bit]) prow = 5'(w - 1) - prow;
    if (w == 16) pre = {code, prow[3:0]};
    else if (w == 32) pre = {code[13:0], prow, 1'b0};
    else pre = {1'b0, code, prow[2:0]};
    top  = pre[rom_aw-1 -: 4];
    k    = px / pixels_per_word;                    // word slot, left to right
    i    = px % pixels_per_word;
    half = hf ^ k[0];
    wbit = (w == 32) && (k[1] ^ hf);
    addr = {(top & cfg_mask) | cfg_offset, pre[rom_aw-5:1], pre[0] | wbit};
    word = rom_word(addr, half);
    if (top > cfg_limit) colour = unmapped_colour;
    else if (hf) colour = {word[24+i], word[16+i], word[8+i], word[i]};
    else colour = {word[31-i], word[23-i], word[15-i], word[7-i]};
    return {attr[8:7], attr[4:0], colour};
endfunction

task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("FAILED %s expected %08h actual %08h", name, exp, act);
    end
endtask

task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("FAILED %s expected %02b actual %02b", name, exp, act);
    end
endtask

task automatic check_pixel(input string name, input int addr,
                           input logic [pixel_w-1:0] exp, input logic [pixel_w-1:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("FAILED %s pixel %0d expected %03h actual %03h", name, addr, exp, act);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("FAILED %s expected %0b actual %0b", name, exp, act);
    end
endtask

task automatic axi_write(input logic [axi_aw-1:0] addr, input logic [31:0] data,
                         input logic [3:0] strb);
    @(posedge clk);
    awaddr  <= addr;
    wdata   <= data;
    wstrb   <= strb;
    awvalid <= 1'b1;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge clk); while (!bvalid);   // bready held high
    last_bresp = bresp;
endtask

task automatic axi_read(input logic [axi_aw-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    do @(posedge clk); while (!rvalid);
    data       = rdata;
    last_rresp = rresp;
endtask

task automatic start_line(input logic [2:0] sz, input logic fl, input logic [15:0] hp,
                          input logic [15:0] vp, input logic [3:0] off,
                          input logic [3:0] msk, input logic [3:0] lim, input logic [8:0] vr);
    cfg_size   = sz;
    cfg_flip   = fl;
    cfg_hpos   = hp;
    cfg_vpos   = vp;
    cfg_offset = off;
    cfg_mask   = msk;
    cfg_limit  = lim;
    axi_write(reg_ctrl, {23'd0, fl, 5'd0, sz}, 4'hf);
    axi_write(reg_hpos, {16'd0, hp}, 4'hf);
    axi_write(reg_vpos, {16'd0, vp}, 4'hf);
    axi_write(reg_bank, {20'd0, lim, msk, off}, 4'hf);
    @(posedge clk);
    vrender   <= vr;
    line_id   <= line_id + 1;
    done_base = done_total;
    late_base = late_total;
    wr_base   = wr_total;
    start     <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
endtask

// wait for done, then make sure the engine stays quiet
task automatic finish_line(input string tname);
    int n;
    n = 0;
    while (done_total == done_base && n < done_limit) begin
        @(posedge clk);
        n++;
    end
    if (done_total == done_base) begin
        errors++;
        $display("%s: done did not arrive within %0d cycles", tname, done_limit);
    end
    repeat (10) @(posedge clk);
    check_flag({tname, " single done pulse"}, 1'b1, done_total - done_base == 1);
    check_flag({tname, " no writes after done"}, 1'b1, late_total == late_base);
endtask

task automatic compare_line(input string tname);
    int a;
    for (a = 0; a < line_pixels; a++) begin
        check_flag($sformatf("%s pixel %0d written", tname, a), 1'b1, wr_line[a] == line_id);
        if (wr_line[a] == line_id) check_pixel(tname, a, expected_pixel(a), line_mem[a]);
    end
endtask

task automatic render_line(input string tname, input logic [2:0] sz, input logic fl,
                           input logic [15:0] hp, input logic [15:0] vp,
                           input logic [3:0] off, input logic [3:0] msk,
                           input logic [3:0] lim, input logic [8:0] vr);
    start_line(sz, fl, hp, vp, off, msk, lim, vr);
    finish_line(tname);
    compare_line(tname);
endtask

task automatic report_test(input string tname, input int e0);
    tests++;
    if (errors == e0) $display("test %s: ok", tname);
    else $display("test %s: %0d errors", tname, errors - e0);
endtask

task automatic test_registers();
    logic [31:0] r;
    int          e0;
    e0 = errors;
    axi_read(reg_status, r);
    check_word("regs status after reset", 32'h0, r);
    check_resp("regs status read response", 2'b00, last_rresp);
    axi_write(reg_ctrl, 32'h0000_0104, 4'hf);
    check_resp("regs ctrl write response", 2'b00, last_bresp);
    axi_read(reg_ctrl, r);
    check_word("regs ctrl", 32'h0000_0104, r);
    axi_write(reg_hpos, 32'hdead_1234, 4'hf);   // upper half not stored
    axi_read(reg_hpos, r);
    check_word("regs hpos", 32'h0000_1234, r);
    axi_write(reg_vpos, 32'h0000_abcd, 4'hf);
    axi_read(reg_vpos, r);
    check_word("regs vpos", 32'h0000_abcd, r);
    axi_write(reg_bank, 32'h0000_0fa5, 4'hf);
    axi_read(reg_bank, r);
    check_word("regs bank", 32'h0000_0fa5, r);
    axi_write(reg_hpos, 32'h0000_ff99, 4'b0001);
    axi_read(reg_hpos, r);
    check_word("regs hpos low byte", 32'h0000_1299, r);
    axi_write(reg_hpos, 32'h0000_56ee, 4'b0010);
    axi_read(reg_hpos, r);
    check_word("regs hpos high byte", 32'h0000_5699, r);
    axi_write(reg_vpos, 32'h0000_7777, 4'b0000);
    axi_read(reg_vpos, r);
    check_word("regs vpos no strobe", 32'h0000_abcd, r);
    axi_write(5'h14, 32'hffff_ffff, 4'hf);
    check_resp("regs unknown write response", 2'b00, last_bresp);
    axi_read(5'h14, r);
    check_word("regs unknown address", 32'h0, r);
    check_resp("regs unknown read response", 2'b00, last_rresp);
    axi_write(reg_status, 32'h1, 4'hf);
    axi_read(reg_status, r);
    check_word("regs status read only", 32'h0, r);
    report_test("registers", e0);
endtask

task automatic test_line_8x8();
    logic [31:0] r;
    int          e0;
    e0 = errors;
    render_line("line 8x8", size_8, 1'b0, 16'h0, 16'h0, 4'h0, 4'hf, 4'hf, 9'd37);
    axi_read(reg_status, r);
    check_word("line 8x8 status done", 32'h1, r);
    report_test("line 8x8", e0);
endtask

task automatic test_line_16x16_flip();
    int e0;
    e0 = errors;
    render_line("line 16x16", size_16, 1'b1, 16'h0005, 16'h0123, 4'h0, 4'hf, 4'hf, 9'd100);
    report_test("line 16x16 flip", e0);
endtask

task automatic test_line_32x32_bank();
    int e0;
    e0 = errors;
    rand_lat = 1'b1;   // ROM answers in 1 to 6 cycles
    render_line("line 32x32", size_32, 1'b0, 16'h0147, 16'h0055, 4'h8, 4'h3, 4'hf, 9'd200);
    rand_lat = 1'b0;
    report_test("line 32x32 bank", e0);
endtask

task automatic test_unmapped();
    int e0;
    e0 = errors;
    render_line("unmapped", size_8, 1'b0, 16'h0013, 16'h0040, 4'h0, 4'hf, 4'h3, 9'd7);
    report_test("unmapped tiles", e0);
endtask

task automatic test_stop_restart();
    logic [31:0] r;
    int          e0;
    int          n;
    e0 = errors;
    start_line(size_8, 1'b0, 16'h0002, 16'h0000, 4'h0, 4'hf, 4'hf, 9'd50);
    axi_read(reg_status, r);
    check_word("stop status cleared by start", 32'h0, r);
    n = 0;
    while (wr_total - wr_base < 120 && n < done_limit) begin
        @(posedge clk);
        n++;
    end
    stop <= 1'b1;
    @(posedge clk);
    stop <= 1'b0;
    finish_line("stop");
    check_flag("stop line cut short", 1'b0, wr_line[line_pixels-1] == line_id);
    render_line("restart", size_8, 1'b0, 16'h0002, 16'h0000, 4'h0, 4'hf, 4'hf, 9'd51);
    report_test("stop and restart", e0);
endtask

initial begin
    int j;
    seed = 32'h6a4c_a523;
    for (j = 0; j < (1 << map_aw); j++) map_mem[j] = 16'($random(seed));
    rst     <= 1'b1;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b1;
    start   <= 1'b0;
    stop    <= 1'b0;
    vrender <= '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_registers();
    test_line_8x8();
    test_line_16x16_flip();
    test_line_32x32_bank();
    test_unmapped();
    test_stop_restart();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
        $display("sim passed");
    end else begin
        $display("sim failed");
    end
    $finish;
end

// watchdog sized for 8 lines at the worst ROM latency
initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, run did not complete", watchdog_ns);
    $display("sim failed");
    $finish;
end

endmodule

`default_nettype wire

/* flist.f */
rtl/scroll_cfg_pkg.sv
rtl/scroll_gfx_pkg.sv
rtl/scroll_regs.sv
rtl/tile_fetch.sv
rtl/pixel_fetch.sv
rtl/scroll_line_top.sv
test/tb_clock.sv
test/scroll_line_tb.sv

/* Makefile */
# Verilator build and run of the scroll line engine testbench
TOP = scroll_line_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
